// File: verilog/dcache_pkg.sv
// --------------------------------------------------
// Data cache shared definitions
// Bus widths, Wishbone cycle types and controller
// states used across the cache RTL
// --------------------------------------------------

package dcache_pkg;

        localparam int ADDR_W = 32;             // Byte address
        localparam int WORD_W = 32;             // Processor and bus word
        localparam int SEL_W  = WORD_W / 8;     // Byte lanes per word

        // Wishbone cycle type identifier
        typedef enum logic [2:0]
        {
                CTI_CLASSIC = 3'b000,
                CTI_INCR    = 3'b010,
                CTI_EOB     = 3'b111
        } wb_cti_e;

        // Controller FSM
        typedef enum logic [2:0]
        {
                ST_IDLE,
                ST_UNCACHED,
                ST_WRITEBACK,
                ST_FETCH,
                ST_INSTALL
        } ctrl_state_e;

endpackage

// File: verilog/dcache_if.sv
// --------------------------------------------------
// Cache internal interfaces
// store_if links the FSM to the tag and data arrays,
// burst_if links the FSM to the Wishbone engine
// --------------------------------------------------

`timescale 1ns/1ps

interface store_if #(
        parameter int CACHE_SIZE = 256,
        parameter int LINE_BYTES = 16
);
        localparam int LINE_W = LINE_BYTES * 8;
        localparam int IDX_W  = $clog2(CACHE_SIZE / LINE_BYTES);
        localparam int TAG_W  = dcache_pkg::ADDR_W - IDX_W - $clog2(LINE_BYTES);

        logic [IDX_W-1:0]       index;
        logic                   wr_en;
        logic [TAG_W-1:0]       wr_tag;
        logic                   wr_dirty;
        logic [LINE_W-1:0]      wr_line;
        logic [LINE_BYTES-1:0]  wr_ben;         // One enable per line byte
        logic [TAG_W-1:0]       rd_tag;
        logic                   rd_valid;
        logic                   rd_dirty;
        logic [LINE_W-1:0]      rd_line;

        modport ctrl  (output index, wr_en, wr_tag, wr_dirty, wr_line, wr_ben,
                       input  rd_tag, rd_valid, rd_dirty, rd_line);
        modport store (input  index, wr_en, wr_tag, wr_dirty, wr_line, wr_ben,
                       output rd_tag, rd_valid, rd_dirty, rd_line);
endinterface

interface burst_if #(
        parameter int LINE_BYTES = 16
);
        logic                           start;          // One cycle, master idle
        logic [dcache_pkg::ADDR_W-1:0]  base;
        logic                           we;
        logic                           single;         // One beat instead of a line
        logic [LINE_BYTES*8-1:0]        wr_line;
        logic [dcache_pkg::WORD_W-1:0]  wr_word;
        logic [dcache_pkg::SEL_W-1:0]   wr_sel;
        logic                           done;
        logic [LINE_BYTES*8-1:0]        rd_line;
        logic [dcache_pkg::WORD_W-1:0]  rd_word;

        modport ctrl   (output start, base, we, single, wr_line, wr_word, wr_sel,
                        input  done, rd_line, rd_word);
        modport master (input  start, base, we, single, wr_line, wr_word, wr_sel,
                        output done, rd_line, rd_word);
endinterface

// File: verilog/dcache_store.sv
// --------------------------------------------------
// Cache store
// Direct-mapped tag, valid, dirty and line arrays,
// asynchronous read, byte-masked write
// --------------------------------------------------

`timescale 1ns/1ps

module dcache_store #(
        parameter int CACHE_SIZE = 256,
        parameter int LINE_BYTES = 16
) (
        input  logic    i_clk,
        input  logic    i_reset,
        store_if.store  st
);

        localparam int LINES  = CACHE_SIZE / LINE_BYTES;
        localparam int LINE_W = LINE_BYTES * 8;
        localparam int TAG_W  = dcache_pkg::ADDR_W - $clog2(LINES) - $clog2(LINE_BYTES);

        logic [TAG_W-1:0]       tag_mem  [LINES];
        logic [LINE_W-1:0]      line_mem [LINES];
        logic [LINES-1:0]       valid_q;
        logic [LINES-1:0]       dirty_q;

        // Lookup by index
        assign st.rd_tag   = tag_mem[st.index];
        assign st.rd_line  = line_mem[st.index];
        assign st.rd_valid = valid_q[st.index];
        assign st.rd_dirty = dirty_q[st.index];

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        valid_q <= '0;
                end
                else if (st.wr_en)
                begin
                        valid_q[st.index] <= 1'b1;      // Any write validates
                end
        end

        // --------------------------------------------------
        // Tag and data update
        // --------------------------------------------------
        always_ff @(posedge i_clk)
        begin
                if (st.wr_en)
                begin
                        tag_mem[st.index] <= st.wr_tag;
                        dirty_q[st.index] <= st.wr_dirty;
                        for (int b = 0; b < LINE_BYTES; b++)
                        begin
                                if (st.wr_ben[b])
                                begin
                                        line_mem[st.index][b*8 +: 8] <= st.wr_line[b*8 +: 8];
                                end
                        end
                end
        end

endmodule

// File: verilog/wb_burst_master.sv
// --------------------------------------------------
// Wishbone burst engine
// Runs one incrementing line burst or a single beat
// per start, through a shared line buffer
// --------------------------------------------------

`timescale 1ns/1ps

module wb_burst_master #(
        parameter int LINE_BYTES = 16
) (
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic                            i_wb_ack,
        input  logic [dcache_pkg::WORD_W-1:0]   i_wb_dat,
        output logic                            o_wb_cyc,
        output logic                            o_wb_stb,
        output logic [dcache_pkg::ADDR_W-1:0]   o_wb_adr,
        output logic [dcache_pkg::WORD_W-1:0]   o_wb_dat,
        output logic [dcache_pkg::SEL_W-1:0]    o_wb_sel,
        output logic                            o_wb_we,
        output dcache_pkg::wb_cti_e             o_wb_cti,
        burst_if.master                         bus
);

        localparam int WORDS = LINE_BYTES / 4;
        localparam int CNT_W = $clog2(WORDS);
        localparam int W     = dcache_pkg::WORD_W;

        logic [CNT_W-1:0]               cnt;            // Current beat
        logic                           single_q;
        logic                           last;
        logic [LINE_BYTES*8-1:0]        line_buf;

        assign last     = single_q || (cnt == CNT_W'(WORDS - 1));
        assign o_wb_stb = o_wb_cyc;                     // No idle beats inside a burst
        assign o_wb_dat = line_buf[cnt*W +: W];
        assign bus.rd_line = line_buf;
        assign bus.rd_word = line_buf[W-1:0];

        // --------------------------------------------------
        // Cycle control
        // --------------------------------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_wb_cyc <= 1'b0;
                        o_wb_we  <= 1'b0;
                        o_wb_cti <= dcache_pkg::CTI_CLASSIC;
                        bus.done <= 1'b0;
                end
                else
                begin
                        bus.done <= 1'b0;
                        if (bus.start)
                        begin
                                o_wb_cyc <= 1'b1;
                                o_wb_we  <= bus.we;
                                o_wb_cti <= bus.single ? dcache_pkg::CTI_EOB
                                                       : dcache_pkg::CTI_INCR;
                        end
                        else if (o_wb_cyc && i_wb_ack)
                        begin
                                if (last)
                                begin
                                        o_wb_cyc <= 1'b0;
                                        o_wb_we  <= 1'b0;
                                        o_wb_cti <= dcache_pkg::CTI_CLASSIC;
                                        bus.done <= 1'b1;
                                end
                                else if (cnt == CNT_W'(WORDS - 2))
                                begin
                                        o_wb_cti <= dcache_pkg::CTI_EOB;  // Next beat is the last
                                end
                        end
                end
        end

        // --------------------------------------------------
        // Address, select and line buffer
        // --------------------------------------------------
        always_ff @(posedge i_clk)
        begin
                if (bus.start)
                begin
                        o_wb_adr <= bus.base;
                        o_wb_sel <= bus.single ? bus.wr_sel : '1;
                        single_q <= bus.single;
                        cnt      <= '0;
                        line_buf <= bus.wr_line;
                        if (bus.single)
                        begin
                                line_buf[W-1:0] <= bus.wr_word;
                        end
                end
                else if (o_wb_cyc && i_wb_ack)
                begin
                        o_wb_adr <= o_wb_adr + dcache_pkg::ADDR_W'(4);
                        cnt      <= cnt + 1'b1;
                        if (!o_wb_we)
                        begin
                                line_buf[cnt*W +: W] <= i_wb_dat;   // Read beat lands in place
                        end
                end
        end

endmodule

// File: verilog/dcache_ctrl.sv
// --------------------------------------------------
// Cache controller
// Hit detection and the FSM that sequences hits,
// victim write-back, line fill and uncached access
// --------------------------------------------------

`timescale 1ns/1ps

module dcache_ctrl #(
        parameter int CACHE_SIZE = 256,
        parameter int LINE_BYTES = 16
) (
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic [dcache_pkg::ADDR_W-1:0]   i_address,
        input  logic                            i_rd,
        input  logic                            i_wr,
        input  logic [dcache_pkg::WORD_W-1:0]   i_din,
        input  logic [dcache_pkg::SEL_W-1:0]    i_ben,
        input  logic                            i_cache_en,
        output logic [dcache_pkg::WORD_W-1:0]   o_dat,
        output logic                            o_ack,
        store_if.ctrl                           st,
        burst_if.ctrl                           bus
);

        localparam int WORDS  = LINE_BYTES / 4;
        localparam int WOFF_W = $clog2(WORDS);
        localparam int OFF_W  = $clog2(LINE_BYTES);
        localparam int IDX_W  = $clog2(CACHE_SIZE / LINE_BYTES);
        localparam int TAG_W  = dcache_pkg::ADDR_W - IDX_W - OFF_W;
        localparam int W      = dcache_pkg::WORD_W;

        logic [TAG_W-1:0]               tag;
        logic [IDX_W-1:0]               idx;
        logic [WOFF_W-1:0]              woff;
        logic                           req;
        logic                           hit;
        dcache_pkg::ctrl_state_e        state_q;
        dcache_pkg::ctrl_state_e        state_d;

        // Address split, byte offset dropped
        assign {tag, idx, woff} = i_address[dcache_pkg::ADDR_W-1:2];

        assign req = i_rd | i_wr;
        assign hit = st.rd_valid && (st.rd_tag == tag);

        // --------------------------------------------------
        // Store update path
        // --------------------------------------------------
        assign st.index    = idx;
        assign st.wr_tag   = tag;
        assign st.wr_dirty = (state_q != dcache_pkg::ST_INSTALL);   // Write hit marks dirty
        assign st.wr_line  = (state_q == dcache_pkg::ST_INSTALL) ? bus.rd_line
                                                                 : {WORDS{i_din}};
        assign st.wr_ben   = (state_q == dcache_pkg::ST_INSTALL) ? '1
                                : LINE_BYTES'(i_ben) << (woff * dcache_pkg::SEL_W);

        // Victim line and single word go out as is
        assign bus.wr_line = st.rd_line;
        assign bus.wr_word = i_din;
        assign bus.wr_sel  = i_ben;

        assign o_dat = (state_q == dcache_pkg::ST_UNCACHED) ? bus.rd_word
                                                            : st.rd_line[woff*W +: W];

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state_q <= dcache_pkg::ST_IDLE;
                end
                else
                begin
                        state_q <= state_d;
                end
        end

        // --------------------------------------------------
        // Next state and outputs
        // --------------------------------------------------
        always_comb
        begin
                state_d    = state_q;
                o_ack      = 1'b0;
                st.wr_en   = 1'b0;
                bus.start  = 1'b0;
                bus.we     = 1'b0;
                bus.single = 1'b0;
                bus.base   = {tag, idx, {OFF_W{1'b0}}};  // Line fill address

                case (state_q)
                dcache_pkg::ST_IDLE:
                begin
                        if (req && !i_cache_en)
                        begin
                                bus.start  = 1'b1;
                                bus.single = 1'b1;
                                bus.we     = i_wr;
                                bus.base   = {i_address[dcache_pkg::ADDR_W-1:2], 2'b00};
                                state_d    = dcache_pkg::ST_UNCACHED;
                        end
                        else if (req && hit)
                        begin
                                o_ack    = 1'b1;
                                st.wr_en = i_wr;
                        end
                        else if (req && st.rd_valid && st.rd_dirty)
                        begin
                                // Victim goes back to its own address
                                bus.start = 1'b1;
                                bus.we    = 1'b1;
                                bus.base  = {st.rd_tag, idx, {OFF_W{1'b0}}};
                                state_d   = dcache_pkg::ST_WRITEBACK;
                        end
                        else if (req)
                        begin
                                bus.start = 1'b1;
                                state_d   = dcache_pkg::ST_FETCH;
                        end
                end

                dcache_pkg::ST_UNCACHED:
                begin
                        if (bus.done)
                        begin
                                o_ack   = 1'b1;
                                state_d = dcache_pkg::ST_IDLE;
                        end
                end

                dcache_pkg::ST_WRITEBACK:
                begin
                        if (bus.done)
                        begin
                                bus.start = 1'b1;       // Fill right behind the write-back
                                state_d   = dcache_pkg::ST_FETCH;
                        end
                end

                dcache_pkg::ST_FETCH:
                begin
                        if (bus.done)
                        begin
                                state_d = dcache_pkg::ST_INSTALL;
                        end
                end

                dcache_pkg::ST_INSTALL:
                begin
                        st.wr_en = 1'b1;        // Clean line, request then hits in idle
                        state_d  = dcache_pkg::ST_IDLE;
                end

                default:
                begin
                        state_d = dcache_pkg::ST_IDLE;
                end
                endcase
        end

endmodule

// File: verilog/dcache_top.sv
// --------------------------------------------------
// Data cache top level
// Write-back direct-mapped cache with a Wishbone
// burst master toward memory
// --------------------------------------------------

`timescale 1ns/1ps

module dcache_top #(
        parameter int CACHE_SIZE = 256,         // Total bytes
        parameter int LINE_BYTES = 16           // Power of two, 8 or more
) (
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic [dcache_pkg::ADDR_W-1:0]   i_address,
        input  logic                            i_rd,
        input  logic                            i_wr,
        input  logic [dcache_pkg::WORD_W-1:0]   i_din,
        input  logic [dcache_pkg::SEL_W-1:0]    i_ben,
        input  logic                            i_cache_en,
        input  logic                            i_wb_ack,
        input  logic [dcache_pkg::WORD_W-1:0]   i_wb_dat,
        output logic [dcache_pkg::WORD_W-1:0]   o_dat,
        output logic                            o_ack,
        output logic                            o_wb_cyc,
        output logic                            o_wb_stb,
        output logic [dcache_pkg::ADDR_W-1:0]   o_wb_adr,
        output logic [dcache_pkg::WORD_W-1:0]   o_wb_dat,
        output logic [dcache_pkg::SEL_W-1:0]    o_wb_sel,
        output logic                            o_wb_we,
        output dcache_pkg::wb_cti_e             o_wb_cti
);

        store_if #(.CACHE_SIZE(CACHE_SIZE), .LINE_BYTES(LINE_BYTES)) st_if ();
        burst_if #(.LINE_BYTES(LINE_BYTES)) bu_if ();

        dcache_ctrl #(.CACHE_SIZE(CACHE_SIZE), .LINE_BYTES(LINE_BYTES)) u_ctrl (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_address  (i_address),
                .i_rd       (i_rd),
                .i_wr       (i_wr),
                .i_din      (i_din),
                .i_ben      (i_ben),
                .i_cache_en (i_cache_en),
                .o_dat      (o_dat),
                .o_ack      (o_ack),
                .st         (st_if.ctrl),
                .bus        (bu_if.ctrl)
        );

        dcache_store #(.CACHE_SIZE(CACHE_SIZE), .LINE_BYTES(LINE_BYTES)) u_store (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .st      (st_if.store)
        );

        wb_burst_master #(.LINE_BYTES(LINE_BYTES)) u_master (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .i_wb_ack (i_wb_ack),
                .i_wb_dat (i_wb_dat),
                .o_wb_cyc (o_wb_cyc),
                .o_wb_stb (o_wb_stb),
                .o_wb_adr (o_wb_adr),
                .o_wb_dat (o_wb_dat),
                .o_wb_sel (o_wb_sel),
                .o_wb_we  (o_wb_we),
                .o_wb_cti (o_wb_cti),
                .bus      (bu_if.master)
        );

endmodule

// File: testbench/dcache_props.sv
// --------------------------------------------------
// Cache bus properties
// Wishbone protocol and reset checks on the top level
// --------------------------------------------------

`timescale 1ns/1ps

module dcache_props (
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic                            i_ack,
        input  logic                            i_wb_cyc,
        input  logic                            i_wb_stb,
        input  logic                            i_wb_ack,
        input  logic [dcache_pkg::ADDR_W-1:0]   i_wb_adr,
        input  logic [dcache_pkg::WORD_W-1:0]   i_wb_dat,
        input  dcache_pkg::wb_cti_e             i_wb_cti
);

        int fail_count = 0;

        task automatic report_failure(string what);
                $error("%s", what);
                fail_count++;
        endtask

        // Strobe stays up inside the cycle until acknowledged
        stb_in_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
                i_wb_stb && !i_wb_ack |=> i_wb_stb && i_wb_cyc)
                else report_failure("stb or cyc dropped before the acknowledge");

        // Quiet during reset and the cycle after
        reset_quiet: assert property (@(posedge i_clk)
                i_reset |=> !i_wb_cyc && !i_wb_stb && !i_ack)
                else report_failure("cyc, stb or ack active around reset");

        hold_on_wait: assert property (@(posedge i_clk) disable iff (i_reset)
                i_wb_stb && !i_wb_ack |=> $stable(i_wb_adr) && $stable(i_wb_dat))
                else report_failure("address or data moved under a withheld ack");

        eob_last: assert property (@(posedge i_clk) disable iff (i_reset)
                $fell(i_wb_cyc) |-> $past(i_wb_cti) == dcache_pkg::CTI_EOB)
                else report_failure("last beat of a cycle without CTI_EOB");

endmodule

bind dcache_top dcache_props u_props (
        .i_ack    (o_ack),
        .i_wb_cyc (o_wb_cyc),
        .i_wb_stb (o_wb_stb),
        .i_wb_adr (o_wb_adr),
        .i_wb_dat (o_wb_dat),
        .i_wb_cti (o_wb_cti),
        .*
);

// File: testbench/tb_dcache.sv
// --------------------------------------------------
// Data cache testbench
// Wishbone memory with wait states, a shadow memory
// model, directed cases and a random access mix
// --------------------------------------------------

`timescale 1ns/1ps

module tb_dcache;

        localparam int OPS     = 300;
        localparam int TIMEOUT = OPS * 60;      // Cycles, worst-case miss well below 60

        logic                   i_clk = 1'b0;
        logic                   i_reset, i_rd, i_wr, i_cache_en;
        logic [31:0]            i_address, i_din;
        logic [3:0]             i_ben;
        logic                   i_wb_ack = 1'b0;
        logic [31:0]            i_wb_dat = '0;
        logic [31:0]            o_dat, o_wb_adr, o_wb_dat;
        logic                   o_ack, o_wb_cyc, o_wb_stb, o_wb_we;
        logic [3:0]             o_wb_sel;
        dcache_pkg::wb_cti_e    o_wb_cti;

        logic [31:0]    mem    [256];           // Wishbone memory, 1 KiB
        logic [31:0]    shadow [256];           // Expected contents as seen through the cache
        int             seed = 90;
        int             wait_cnt = 0;
        int             cycles = 0;
        int             beats = 0;
        int             wr_beats = 0;

        dcache_top #(.CACHE_SIZE(256), .LINE_BYTES(16)) dcache_top_inst (.*);

        always #2 i_clk = ~i_clk;

        // Byte-lane merge shared by memory and shadow
        function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] data,
                                                    logic [3:0] be);
                logic [31:0] res;
                res = old;
                for (int b = 0; b < 4; b++)
                        if (be[b])
                                res[b*8 +: 8] = data[b*8 +: 8];
                return res;
        endfunction

        task automatic abort_run(string what);
                $display("%s", what);
                $display("*** TEST FAILED ***");
                $fatal(1, "simulation stopped on first error");
        endtask

        // --------------------------------------------------
        // Watchdog and bus model
        // --------------------------------------------------
        always @(posedge i_clk)
        begin
                cycles++;
                if (cycles >= TIMEOUT)
                        abort_run("run timed out before all accesses finished");
                else if (dcache_top_inst.u_props.fail_count != 0)
                        abort_run("a bound Wishbone protocol assertion failed");
        end

        // Slave acks after 0 to 3 random wait cycles
        always @(negedge i_clk)
        begin
                if (o_wb_cyc && o_wb_stb && wait_cnt == 0)
                begin
                        i_wb_ack = 1'b1;
                        i_wb_dat = mem[o_wb_adr[9:2]];
                        if (o_wb_we)
                                mem[o_wb_adr[9:2]] = merge_bytes(mem[o_wb_adr[9:2]],
                                                                 o_wb_dat, o_wb_sel);
                        wait_cnt = $unsigned($random(seed)) % 4;
                end
                else
                begin
                        i_wb_ack = 1'b0;
                        if (o_wb_cyc && wait_cnt != 0)
                                wait_cnt--;
                end
        end

        always @(posedge i_clk)
        begin
                if (o_wb_cyc && i_wb_ack)
                begin
                        beats++;
                        if (o_wb_we)
                                wr_beats++;
                end
        end

        // Every acknowledged read against the shadow
        always @(posedge i_clk)
        begin
                if (o_ack && i_rd)
                        assert (o_dat === shadow[i_address[9:2]])
                        else abort_run($sformatf("mismatch at %0t: read %h from %h, expected %h",
                                                 $time, o_dat, i_address,
                                                 shadow[i_address[9:2]]));
        end

        // One processor request, held until acked
        task automatic access(bit write, logic [31:0] addr, logic [31:0] data, logic [3:0] be);
                @(negedge i_clk);
                i_address = addr;
                i_din     = data;
                i_ben     = be;
                i_rd      = !write;
                i_wr      = write;
                @(posedge i_clk);
                while (!o_ack)
                        @(posedge i_clk);
                if (write)
                        shadow[addr[9:2]] = merge_bytes(shadow[addr[9:2]], data, be);
                @(negedge i_clk);
                i_rd = 1'b0;
                i_wr = 1'b0;
        endtask

        // --------------------------------------------------
        // Stimulus
        // --------------------------------------------------
        initial
        begin
                logic [31:0]    addr;
                bit             en;
                for (int i = 0; i < 256; i++)
                begin
                        mem[i]    = $random(seed);
                        shadow[i] = mem[i];
                end
                i_reset    = 1'b1;
                i_rd       = 1'b0;
                i_wr       = 1'b0;
                i_cache_en = 1'b1;
                i_address  = '0;
                i_din      = '0;
                i_ben      = '0;
                repeat (8) @(negedge i_clk);
                i_reset = 1'b0;
                @(posedge i_clk);
                assert (!o_ack && !o_wb_cyc && !o_wb_stb)
                else abort_run("ack or bus cycle active right after reset");

                // Miss fills the line, rereads hit
                access(0, 32'h040, 0, 0);
                for (int w = 0; w < 4; w++)
                        access(0, 32'h040 + w * 4, 0, 0);
                assert (beats == 4 && wr_beats == 0)
                else abort_run("line fill was not a single 4-beat read burst");

                beats = 0;
                access(1, 32'h044, 32'ha5c3_0f96, 4'b0101);
                access(0, 32'h044, 0, 0);
                assert (beats == 0)
                else abort_run("write hit or read hit went out on the bus");

                // Same index, other tag, dirty victim goes back first
                access(0, 32'h140, 0, 0);
                assert (beats == 8 && wr_beats == 4)
                else abort_run("eviction did not write back the line before the fill");
                for (int w = 16; w < 20; w++)
                        assert (mem[w] === shadow[w])
                        else abort_run($sformatf("mismatch at %0t: memory word %0d is %h",
                                                 $time, w, mem[w]));

                i_cache_en = 1'b0;
                beats = 0;
                access(1, 32'h300, 32'h1234_5678, 4'b0011);
                access(0, 32'h300, 0, 0);
                assert (beats == 2)
                else abort_run("uncached accesses did not run as single beats");

                // Random mix, uncached traffic kept in the top 256 bytes
                for (int n = 0; n < OPS; n++)
                begin
                        en   = 1'($random(seed));
                        addr = $random(seed);
                        i_cache_en = en;
                        if (en)
                                addr = (addr % 32'h300) & ~32'h3;
                        else
                                addr = {22'd0, 2'b11, addr[7:2], 2'b00};
                        access(1'($random(seed)), addr, $random(seed), 4'($random(seed)));
                end
                if (dcache_top_inst.u_props.fail_count != 0)
                        abort_run("a bound Wishbone protocol assertion failed");
                else
                begin
                        $display("*** TEST PASSED ***");
                        $finish;
                end
        end

endmodule

// File: list.f
verilog/dcache_pkg.sv
verilog/dcache_if.sv
verilog/dcache_store.sv
verilog/wb_burst_master.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
testbench/dcache_props.sv
testbench/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/dcache_if.sv
  - verilog/dcache_store.sv
  - verilog/wb_burst_master.sv
  - verilog/dcache_ctrl.sv
  - verilog/dcache_top.sv
  - target: test
    files:
      - testbench/dcache_props.sv
      - testbench/tb_dcache.sv
